// File: include/dec_lag3_cfg.svh
`ifndef DEC_LAG3_CFG_SVH
`define DEC_LAG3_CFG_SVH

// Lane and channel count
`define DL3_LANES 4

// FIFO depth and credits per link
`define DL3_CREDITS 2

// Scratch memory
`define DL3_ADDR_W 12
`define DL3_LAG_BASE 12'h040

// Pitch lag limits
`define DL3_PIT_MIN 20
`define DL3_PIT_MAX 143

// Previous lag after reset
`define DL3_T0_INIT 60

`endif

// File: hdl/dec_lag3_pkg.sv
`include "dec_lag3_cfg.svh"

package dec_lag3_pkg;

	// Received pitch index, 8 bits on subframe 0, low 5 bits on subframe 1
	typedef logic [7:0] pitch_index_t;

	// Integer pitch lag T0
	typedef logic [7:0] lag_t;

	// Fractional lag, -1 to 1
	typedef logic signed [1:0] lag_frac_t;

	// Channel number, one channel per lane
	typedef logic [$clog2(`DL3_LANES)-1:0] chan_t;

	// Credit counter, 0 to DL3_CREDITS
	typedef logic [$clog2(`DL3_CREDITS+1)-1:0] credit_t;

	// Request payload: index in 8:1, subframe flag in 0
	typedef logic [8:0] lag_req_t;

	// Result payload: fraction in 9:8, T0 in 7:0 (same as the memory word)
	typedef logic [9:0] lag_res_t;

endpackage

// File: hdl/lag_fifo.sv
`timescale 1ns/1ps

module lag_fifo #(
	parameter type T     = logic [7:0],
	parameter int  DEPTH = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  logic push,
	input  T     din,
	input  logic pop,
	output T     dout,
	output logic empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T                   mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;

	// Storage, no overflow check since the sender holds credits
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	assign dout  = mem[rd_ptr];
	assign empty = (count == '0);

endmodule

// File: hdl/lag_dispatch.sv
`timescale 1ns/1ps
`include "dec_lag3_cfg.svh"

module lag_dispatch import dec_lag3_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  pitch_index_t          lag_index,
	input  logic                  i_subfr,
	input  chan_t                 chan,
	output logic                  ready,
	output logic [`DL3_LANES-1:0] req_push,
	output pitch_index_t          req_index,
	output logic                  req_subfr,
	input  logic [`DL3_LANES-1:0] req_credit
);

	credit_t               credit_cnt [`DL3_LANES];
	logic [`DL3_LANES-1:0] chan_sel;
	logic                  accept;

	// One-hot lane select from channel number
	always_comb begin
		chan_sel       = '0;
		chan_sel[chan] = 1'b1;
	end

	assign ready  = (credit_cnt[chan] != '0);
	assign accept = start && ready;

	////////////////////////////////////////////////////////////////////////////
	// Credit counters, one per lane
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int n = 0; n < `DL3_LANES; n++)
				credit_cnt[n] <= credit_t'(`DL3_CREDITS);
			req_push <= '0;
		end else begin
			for (int n = 0; n < `DL3_LANES; n++)
				credit_cnt[n] <= credit_cnt[n]
					- credit_t'(accept && chan_sel[n])
					+ credit_t'(req_credit[n]);
			req_push <= accept ? chan_sel : '0;
		end
	end

	// Payload is shared by all lanes, only the push is per lane
	always_ff @(posedge clk) begin
		if (accept) begin
			req_index <= lag_index;
			req_subfr <= i_subfr;
		end
	end

endmodule

// File: hdl/lag_decode_lane.sv
`timescale 1ns/1ps
`include "dec_lag3_cfg.svh"

module lag_decode_lane import dec_lag3_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         req_push,
	input  pitch_index_t req_index,
	input  logic         req_subfr,
	output logic         req_credit,
	output logic         res_push,
	output lag_t         res_t0,
	output lag_frac_t    res_frac,
	input  logic         res_credit
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_DIV,
		S_LAG,
		S_OUT
	} lane_state_t;

	lane_state_t  state;
	lag_req_t     fifo_din;
	lag_req_t     fifo_dout;
	logic         fifo_empty;
	logic         pop;
	logic         do_push;

	pitch_index_t cur_index;
	logic         cur_subfr;
	lag_t         prev_lag;
	credit_t      res_cnt;

	logic [8:0]   dividend;
	logic [17:0]  prod;
	logic [8:0]   quot_c;
	logic [8:0]   rem_c;
	lag_t         tmin_c;
	lag_t         quot;
	logic [1:0]   rem;
	lag_t         tmin;
	lag_t         t0_c;
	lag_frac_t    frac_c;

	assign fifo_din = {req_index, req_subfr};

	lag_fifo #(
		.T     (lag_req_t),
		.DEPTH (`DL3_CREDITS)
	) req_fifo_i (
		.clk   (clk),
		.rst_n (rst_n),
		.push  (req_push),
		.din   (fifo_din),
		.pop   (pop),
		.dout  (fifo_dout),
		.empty (fifo_empty)
	);

	assign pop     = (state == S_IDLE) && !fifo_empty;
	assign do_push = (state == S_OUT) && (res_cnt != '0);

	////////////////////////////////////////////////////////////////////////////
	// Lag arithmetic
	////////////////////////////////////////////////////////////////////////////

	// (index + 2) / 3 as multiply by 171 / 512, exact below 512
	assign dividend = cur_subfr ? 9'(cur_index[4:0]) + 9'd2 : 9'(cur_index) + 9'd2;
	assign prod     = 18'(dividend) * 18'd171;
	assign quot_c   = prod[17:9];
	// Remainder 0..2, fraction is remainder minus one on both subframes
	assign rem_c    = dividend - (quot_c + {quot_c[7:0], 1'b0});

	// Search window for subframe 1
	always_comb begin
		if (prev_lag < lag_t'(`DL3_PIT_MIN + 5))
			tmin_c = lag_t'(`DL3_PIT_MIN);
		else
			tmin_c = prev_lag - 8'd5;
		if (tmin_c + 8'd9 > lag_t'(`DL3_PIT_MAX))
			tmin_c = lag_t'(`DL3_PIT_MAX - 9);
	end

	always_comb begin
		if (cur_subfr) begin
			t0_c   = tmin + quot - 8'd1;
			frac_c = lag_frac_t'(rem - 2'd1);
		end else if (cur_index < 8'd197) begin
			t0_c   = quot + 8'd19;
			frac_c = lag_frac_t'(rem - 2'd1);
		end else begin
			t0_c   = cur_index - 8'd112;
			frac_c = '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Lane FSM, pop to res_push in four cycles
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			prev_lag   <= lag_t'(`DL3_T0_INIT);
			res_cnt    <= credit_t'(`DL3_CREDITS);
			req_credit <= 1'b0;
			res_push   <= 1'b0;
		end else begin
			req_credit <= pop;
			res_push   <= do_push;
			res_cnt    <= res_cnt - credit_t'(do_push) + credit_t'(res_credit);
			case (state)
				S_IDLE: if (pop) state <= S_DIV;
				S_DIV: state <= S_LAG;
				S_LAG: begin
					prev_lag <= t0_c;
					state    <= S_OUT;
				end
				// Hold here until the collector has room
				S_OUT: if (do_push) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk) begin
		if (pop) begin
			cur_index <= fifo_dout[8:1];
			cur_subfr <= fifo_dout[0];
		end
		if (state == S_DIV) begin
			quot <= quot_c[7:0];
			rem  <= rem_c[1:0];
			tmin <= tmin_c;
		end
		if (state == S_LAG) begin
			res_t0   <= t0_c;
			res_frac <= frac_c;
		end
	end

endmodule

// File: hdl/lag_collect.sv
`timescale 1ns/1ps
`include "dec_lag3_cfg.svh"

module lag_collect import dec_lag3_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`DL3_LANES-1:0] res_push,
	input  lag_t                  res_t0 [`DL3_LANES],
	input  lag_frac_t             res_frac [`DL3_LANES],
	output logic [`DL3_LANES-1:0] res_credit,
	output logic                  mem_wr_en,
	output logic [`DL3_ADDR_W-1:0] mem_wr_addr,
	output logic [31:0]           mem_wr_data,
	output logic                  done,
	output chan_t                 done_chan,
	output lag_t                  t0,
	output lag_frac_t             t0_frac
);

	logic [`DL3_LANES-1:0] fifo_empty;
	logic [`DL3_LANES-1:0] pop;
	lag_res_t              fifo_dout [`DL3_LANES];
	chan_t                 rr_ptr;
	chan_t                 sel;
	logic                  any;

	for (genvar n = 0; n < `DL3_LANES; n++) begin : g_res_fifo
		lag_fifo #(
			.T     (lag_res_t),
			.DEPTH (`DL3_CREDITS)
		) res_fifo_i (
			.clk   (clk),
			.rst_n (rst_n),
			.push  (res_push[n]),
			.din   ({res_frac[n], res_t0[n]}),
			.pop   (pop[n]),
			.dout  (fifo_dout[n]),
			.empty (fifo_empty[n])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Round-robin pick, starting at rr_ptr
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		int unsigned j;
		any = 1'b0;
		sel = rr_ptr;
		pop = '0;
		for (int k = 0; k < `DL3_LANES; k++) begin
			j = int'(rr_ptr) + k;
			if (j >= `DL3_LANES)
				j = j - `DL3_LANES;
			if (!any && !fifo_empty[j]) begin
				any = 1'b1;
				sel = chan_t'(j);
			end
		end
		if (any)
			pop[sel] = 1'b1;
	end

	// Credit goes back to the lane on the pop itself
	assign res_credit = pop;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rr_ptr    <= '0;
			mem_wr_en <= 1'b0;
			done      <= 1'b0;
		end else begin
			mem_wr_en <= any;
			done      <= any;
			if (any)
				rr_ptr <= (sel == chan_t'(`DL3_LANES - 1)) ? '0 : sel + 1'b1;
		end
	end

	// Result word and done payload
	always_ff @(posedge clk) begin
		if (any) begin
			mem_wr_addr <= `DL3_ADDR_W'(`DL3_LAG_BASE) + `DL3_ADDR_W'(sel);
			mem_wr_data <= {22'd0, fifo_dout[sel]};
			done_chan   <= sel;
			t0          <= fifo_dout[sel][7:0];
			t0_frac     <= fifo_dout[sel][9:8];
		end
	end

endmodule

// File: hdl/scratch_mem.sv
`timescale 1ns/1ps
`include "dec_lag3_cfg.svh"

module scratch_mem (
	input  logic                   clk,
	input  logic                   test_sel,
	input  logic                   dec_wr_en,
	input  logic [`DL3_ADDR_W-1:0] dec_wr_addr,
	input  logic [31:0]            dec_wr_data,
	input  logic                   test_wr_en,
	input  logic [`DL3_ADDR_W-1:0] test_wr_addr,
	input  logic [31:0]            test_wr_data,
	input  logic [`DL3_ADDR_W-1:0] rd_addr,
	output logic [31:0]            rd_data
);

	logic [31:0]            ram [2**`DL3_ADDR_W];
	logic                   wr_en;
	logic [`DL3_ADDR_W-1:0] wr_addr;
	logic [31:0]            wr_data;

	// Test port owns the write side while selected
	always_comb begin
		if (test_sel) begin
			wr_en   = test_wr_en;
			wr_addr = test_wr_addr;
			wr_data = test_wr_data;
		end else begin
			wr_en   = dec_wr_en;
			wr_addr = dec_wr_addr;
			wr_data = dec_wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			ram[wr_addr] <= wr_data;
		rd_data <= ram[rd_addr];
	end

endmodule

// File: hdl/dec_lag3_pipe.sv
`timescale 1ns/1ps
`include "dec_lag3_cfg.svh"

module dec_lag3_pipe import dec_lag3_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  pitch_index_t           lag_index,
	input  logic                   i_subfr,
	input  chan_t                  chan,
	input  logic                   test_sel,
	input  logic                   test_wr_en,
	input  logic [`DL3_ADDR_W-1:0] test_wr_addr,
	input  logic [31:0]            test_wr_data,
	input  logic [`DL3_ADDR_W-1:0] test_rd_addr,
	output logic                   ready,
	output logic                   done,
	output chan_t                  done_chan,
	output lag_t                   t0,
	output lag_frac_t              t0_frac,
	output logic [31:0]            scratch_rd_data
);

	logic [`DL3_LANES-1:0]  req_push;
	logic [`DL3_LANES-1:0]  req_credit;
	pitch_index_t           req_index;
	logic                   req_subfr;
	logic [`DL3_LANES-1:0]  res_push;
	logic [`DL3_LANES-1:0]  res_credit;
	lag_t                   res_t0 [`DL3_LANES];
	lag_frac_t              res_frac [`DL3_LANES];
	logic                   mem_wr_en;
	logic [`DL3_ADDR_W-1:0] mem_wr_addr;
	logic [31:0]            mem_wr_data;

	lag_dispatch dispatch_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.lag_index  (lag_index),
		.i_subfr    (i_subfr),
		.chan       (chan),
		.ready      (ready),
		.req_push   (req_push),
		.req_index  (req_index),
		.req_subfr  (req_subfr),
		.req_credit (req_credit)
	);

	////////////////////////////////////////////////////////////////////////////
	// Decode lanes, lane n owns channel n
	////////////////////////////////////////////////////////////////////////////
	for (genvar n = 0; n < `DL3_LANES; n++) begin : g_lane
		lag_decode_lane lane_i (
			.clk        (clk),
			.rst_n      (rst_n),
			.req_push   (req_push[n]),
			.req_index  (req_index),
			.req_subfr  (req_subfr),
			.req_credit (req_credit[n]),
			.res_push   (res_push[n]),
			.res_t0     (res_t0[n]),
			.res_frac   (res_frac[n]),
			.res_credit (res_credit[n])
		);
	end

	lag_collect collect_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.res_push    (res_push),
		.res_t0      (res_t0),
		.res_frac    (res_frac),
		.res_credit  (res_credit),
		.mem_wr_en   (mem_wr_en),
		.mem_wr_addr (mem_wr_addr),
		.mem_wr_data (mem_wr_data),
		.done        (done),
		.done_chan   (done_chan),
		.t0          (t0),
		.t0_frac     (t0_frac)
	);

	scratch_mem mem_i (
		.clk          (clk),
		.test_sel     (test_sel),
		.dec_wr_en    (mem_wr_en),
		.dec_wr_addr  (mem_wr_addr),
		.dec_wr_data  (mem_wr_data),
		.test_wr_en   (test_wr_en),
		.test_wr_addr (test_wr_addr),
		.test_wr_data (test_wr_data),
		.rd_addr      (test_rd_addr),
		.rd_data      (scratch_rd_data)
	);

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset held low over two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

// File: verif/dec_lag3_asserts.sv
`timescale 1ns/1ps
`include "dec_lag3_cfg.svh"

module dec_lag3_asserts import dec_lag3_pkg::*; #(
	parameter bit AT_DISPATCH = 1'b1
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start,
	input  logic    ready,
	input  credit_t credit_cnt [`DL3_LANES],
	input  logic    done
);

	int unsigned fail_count = 0;

	if (AT_DISPATCH) begin : g_dispatch
		// No request into a lane without credit
		a_start_ready: assert property (@(posedge clk) disable iff (!rst_n) start |-> ready)
			else begin
				$error("start seen while ready was low");
				fail_count++;
			end

		// Counter wraps to 3 on underflow, so one bound covers both ends
		for (genvar n = 0; n < `DL3_LANES; n++) begin : g_credit
			a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
				credit_cnt[n] <= credit_t'(`DL3_CREDITS))
				else begin
					$error("request credit of lane %0d out of range", n);
					fail_count++;
				end
		end

		a_reset_ready: assert property (@(posedge clk) $rose(rst_n) |-> ready)
			else begin
				$error("ready low in the first cycle after reset");
				fail_count++;
			end
	end else begin : g_collect
		a_reset_done: assert property (@(posedge clk) $rose(rst_n) |-> !done)
			else begin
				$error("done high in the first cycle after reset");
				fail_count++;
			end
	end

endmodule

// File: verif/dec_lag3_tb.sv
`timescale 1ns/1ps
`include "dec_lag3_cfg.svh"

module dec_lag3_tb import dec_lag3_pkg::*; ();

	localparam int SF0_N       = 9;
	localparam int PAIR_N      = 6;
	localparam int BURST_N     = 200;
	localparam int REQ_TOTAL   = `DL3_LANES * (1 + SF0_N + 2 * PAIR_N) + BURST_N;
	localparam int CYCLE_LIMIT = REQ_TOTAL * 12 + 200;

	logic                   clk;
	logic                   rst_n;
	logic                   start;
	pitch_index_t           lag_index;
	logic                   i_subfr;
	chan_t                  chan;
	logic                   test_sel;
	logic                   test_wr_en;
	logic [`DL3_ADDR_W-1:0] test_wr_addr;
	logic [31:0]            test_wr_data;
	logic [`DL3_ADDR_W-1:0] test_rd_addr;
	logic                   ready;
	logic                   done;
	chan_t                  done_chan;
	lag_t                   t0;
	lag_frac_t              t0_frac;
	logic [31:0]            scratch_rd_data;

	// Reference state per channel
	int          prev_t0 [`DL3_LANES];
	logic [9:0]  exp_q [`DL3_LANES][$];
	logic [9:0]  last_word [`DL3_LANES];

	int          issued = 0;
	int          completed = 0;
	int          errors = 0;
	int          cycles = 0;
	int          seed = 32'hf3dc3c98;

	// Both index classes of subframe 0, with the edges 0, 196, 197, 255
	int sf0_list [SF0_N]  = '{0, 1, 2, 3, 100, 196, 197, 200, 255};
	// Subframe 0 then 1: clamp at 20, clamp at 143, boundary 139, plain window
	int pair_sf0 [PAIR_N] = '{0, 3, 255, 251, 250, 220};
	int pair_sf1 [PAIR_N] = '{17, 0, 31, 31, 5, 12};

	tb_clk_gen clk_gen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	dec_lag3_pipe dut_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.start           (start),
		.lag_index       (lag_index),
		.i_subfr         (i_subfr),
		.chan            (chan),
		.test_sel        (test_sel),
		.test_wr_en      (test_wr_en),
		.test_wr_addr    (test_wr_addr),
		.test_wr_data    (test_wr_data),
		.test_rd_addr    (test_rd_addr),
		.ready           (ready),
		.done            (done),
		.done_chan       (done_chan),
		.t0              (t0),
		.t0_frac         (t0_frac),
		.scratch_rd_data (scratch_rd_data)
	);

	bind lag_dispatch dec_lag3_asserts #(.AT_DISPATCH(1'b1)) disp_chk_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.ready       (ready),
		.credit_cnt  (credit_cnt),
		.done        (1'b0)
	);

	bind lag_collect dec_lag3_asserts #(.AT_DISPATCH(1'b0)) coll_chk_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (1'b0),
		.ready       (1'b0),
		.credit_cnt  (),
		.done        (done)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference decode, returns fraction in 9:8 and T0 in 7:0
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [9:0] model_lag(input int c, input int idx, input bit subfr);
		int t0_e;
		int frac_e;
		int tmin;
		int tmax;
		int i;
		int k;
		if (!subfr) begin
			if (idx < 197) begin
				t0_e   = (idx + 2) / 3 + 19;
				frac_e = idx - 3 * t0_e + 58;
			end else begin
				t0_e   = idx - 112;
				frac_e = 0;
			end
		end else begin
			k    = idx % 32;
			tmin = prev_t0[c] - 5;
			if (tmin < `DL3_PIT_MIN)
				tmin = `DL3_PIT_MIN;
			tmax = tmin + 9;
			if (tmax > `DL3_PIT_MAX) begin
				tmax = `DL3_PIT_MAX;
				tmin = `DL3_PIT_MAX - 9;
			end
			i      = (k + 2) / 3 - 1;
			t0_e   = tmin + i;
			frac_e = k - 2 - 3 * i;
		end
		prev_t0[c] = t0_e;
		return {frac_e[1:0], t0_e[7:0]};
	endfunction

	function automatic logic [31:0] fill_word(input logic [`DL3_ADDR_W-1:0] addr);
		return {4'ha, addr, 4'h5, ~addr};
	endfunction

	// Called 1 ns after an edge, returns 1 ns after an edge
	task automatic issue_req(input int c, input int idx, input bit subfr);
		logic [9:0] word;
		chan      = chan_t'(c);
		lag_index = pitch_index_t'(idx);
		i_subfr   = subfr;
		@(posedge clk);
		while (!ready)
			@(posedge clk);
		#1;
		start = 1'b1;
		word  = model_lag(c, idx, subfr);
		exp_q[c].push_back(word);
		last_word[c] = word;
		issued++;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic wait_idle();
		while (completed != issued)
			@(posedge clk);
		#1;
	endtask

	// One cycle of read latency, sampled on the edge after it
	task automatic check_word(input logic [`DL3_ADDR_W-1:0] addr, input logic [31:0] exp_data);
		test_rd_addr = addr;
		@(posedge clk);
		@(posedge clk);
		assert (scratch_rd_data == exp_data) else begin
			$display("FAIL scratch_rd_data at %h: got %h expected %h",
				addr, scratch_rd_data, exp_data);
			errors++;
		end
		#1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Result checks on done
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		logic [9:0] exp_w;
		if (rst_n && done) begin
			completed++;
			if (exp_q[done_chan].size() == 0) begin
				$display("Unexpected done on channel %0d with no request outstanding", done_chan);
				errors++;
			end else begin
				exp_w = exp_q[done_chan].pop_front();
				assert (t0 == exp_w[7:0]) else begin
					$display("FAIL t0 on channel %0d: got %h expected %h",
						done_chan, t0, exp_w[7:0]);
					errors++;
				end
				assert (t0_frac == exp_w[9:8]) else begin
					$display("FAIL t0_frac on channel %0d: got %h expected %h",
						done_chan, t0_frac, exp_w[9:8]);
					errors++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with %0d of %0d results seen",
				cycles, completed, issued);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		logic [31:0]            r;
		logic [`DL3_ADDR_W-1:0] addr;
		int                     assert_fails;

		start        = 1'b0;
		lag_index    = '0;
		i_subfr      = 1'b0;
		chan         = '0;
		test_sel     = 1'b0;
		test_wr_en   = 1'b0;
		test_wr_addr = '0;
		test_wr_data = '0;
		test_rd_addr = '0;
		for (int c = 0; c < `DL3_LANES; c++)
			prev_t0[c] = `DL3_T0_INIT;

		@(posedge rst_n);
		@(posedge clk);
		#1;

		// Subframe 1 first, against the reset lag
		for (int c = 0; c < `DL3_LANES; c++)
			issue_req(c, 7 + 5 * c, 1'b1);

		for (int k = 0; k < SF0_N; k++)
			for (int c = 0; c < `DL3_LANES; c++)
				issue_req(c, sf0_list[k], 1'b0);

		for (int k = 0; k < PAIR_N; k++) begin
			for (int c = 0; c < `DL3_LANES; c++) begin
				issue_req(c, pair_sf0[k], 1'b0);
				issue_req(c, pair_sf1[k], 1'b1);
			end
		end

		// Random burst over all channels
		for (int k = 0; k < BURST_N; k++) begin
			r = $random(seed);
			issue_req(int'(r[15:0]) % `DL3_LANES, int'(r[23:16]), r[24]);
		end
		wait_idle();

		for (int c = 0; c < `DL3_LANES; c++)
			check_word(`DL3_ADDR_W'(`DL3_LAG_BASE) + `DL3_ADDR_W'(c), {22'd0, last_word[c]});

		////////////////////////////////////////////////////////////////////////
		// Test port owns the write side
		////////////////////////////////////////////////////////////////////////
		test_sel = 1'b1;
		for (int k = 0; k < 8; k++) begin
			addr         = `DL3_ADDR_W'(12'h200 + 37 * k);
			test_wr_en   = 1'b1;
			test_wr_addr = addr;
			test_wr_data = fill_word(addr);
			@(posedge clk);
			#1;
		end
		test_wr_en = 1'b0;
		for (int k = 0; k < 8; k++) begin
			addr = `DL3_ADDR_W'(12'h200 + 37 * k);
			check_word(addr, fill_word(addr));
		end
		test_sel = 1'b0;

		if (completed != issued) begin
			$display("Result count does not match request count");
			errors++;
		end

		assert_fails = dut_i.dispatch_i.disp_chk_i.fail_count
			+ dut_i.collect_i.coll_chk_i.fail_count;
		$display("Run complete: %0d requests, %0d results, %0d errors, %0d assertion failures",
			issued, completed, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: project.f
+incdir+include
hdl/dec_lag3_pkg.sv
hdl/lag_fifo.sv
hdl/lag_dispatch.sv
hdl/lag_decode_lane.sv
hdl/lag_collect.sv
hdl/scratch_mem.sv
hdl/dec_lag3_pipe.sv
verif/tb_clk_gen.sv
verif/dec_lag3_asserts.sv
verif/dec_lag3_tb.sv

// File: Makefile
TOP = dec_lag3_tb

all: run

build:
	verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module $(TOP) -f project.f -o sim

run: build
	./obj_dir/sim 2>&1 | tee sim.log
	grep -q "^All tests passed$$" sim.log

lint:
	verilator --lint-only --assert --timing --timescale 1ns/1ps --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
